/* sim.f */
hdl/kbd_pkg.sv
hdl/ps2_rx.sv
hdl/scan_code_decoder.sv
hdl/key_state.sv
hdl/keyboard_top.sv
verification/ps2_keyboard_model.sv
verification/tb_keyboard_top.sv

/* Bender.yml */
package:
  name: ps2_keyboard_tracker

sources:
  - files:
      - hdl/kbd_pkg.sv
      - hdl/ps2_rx.sv
      - hdl/scan_code_decoder.sv
      - hdl/key_state.sv
      - hdl/keyboard_top.sv
  - target: simulation
    files:
      - verification/ps2_keyboard_model.sv
      - verification/tb_keyboard_top.sv

/* verification/tb_keyboard_top.sv */
`timescale 1ns/1ns

module tb_keyboard_top;

    // Keyboard clock half period in CLOCK_50 cycles
    localparam int HALF_PERIOD = 20;
    localparam int MAX_ROWS    = 16;

    logic              CLOCK_50 = 1'b0;
    logic              reset;
    logic              pulse_mode;
    logic              ps2_clk;
    logic              ps2_dat;
    kbd_pkg::key_vec_t keys;

    // Request handshake towards the keyboard model
    logic                send;
    kbd_pkg::scan_byte_t send_byte;
    logic                bad_parity;
    logic                busy;

    // Stimulus table, first byte in the top bits of row_seq
    string             row_name   [MAX_ROWS];
    logic              row_pulse  [MAX_ROWS];
    int                row_len    [MAX_ROWS];
    logic [31:0]       row_seq    [MAX_ROWS];
    logic              row_bad    [MAX_ROWS];
    kbd_pkg::key_vec_t row_keys   [MAX_ROWS];
    int                row_pulses [MAX_ROWS];
    int                num_rows   = 0;

    int   pass_count = 0;
    int   fail_count = 0;
    int   pulse_cnt  = 0;
    logic counting   = 1'b0;
    logic row_failed;

    always #4 CLOCK_50 = ~CLOCK_50;

    keyboard_top keyboard_top_i (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .pulse_mode (pulse_mode),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .keys       (keys)
    );

    ps2_keyboard_model #(.HALF_PERIOD(HALF_PERIOD)) ps2_keyboard_model_i (
        .CLOCK_50   (CLOCK_50),
        .send       (send),
        .send_byte  (send_byte),
        .bad_parity (bad_parity),
        .busy       (busy),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat)
    );

    // Cycles with any key output high, sampled mid cycle
    always @(negedge CLOCK_50) begin
        if (counting && (keys != '0)) begin
            pulse_cnt = pulse_cnt + 1;
        end
    end

    function automatic kbd_pkg::key_vec_t key_bit(input kbd_pkg::key_idx_t k);
        key_bit    = '0;
        key_bit[k] = 1'b1;
    endfunction

    task automatic add_row(input string name, input logic pulse, input int len,
                           input logic [31:0] seq, input logic bad,
                           input kbd_pkg::key_vec_t exp_keys, input int exp_pulses);
        row_name[num_rows]   = name;
        row_pulse[num_rows]  = pulse;
        row_len[num_rows]    = len;
        row_seq[num_rows]    = seq;
        row_bad[num_rows]    = bad;
        row_keys[num_rows]   = exp_keys;
        row_pulses[num_rows] = exp_pulses;
        num_rows++;
    endtask

    task automatic load_table();
        kbd_pkg::key_vec_t w;
        kbd_pkg::key_vec_t a;
        kbd_pkg::key_vec_t d;
        kbd_pkg::key_vec_t right;
        kbd_pkg::key_vec_t enter;
        w     = key_bit(kbd_pkg::KEY_W);
        a     = key_bit(kbd_pkg::KEY_A);
        d     = key_bit(kbd_pkg::KEY_D);
        right = key_bit(kbd_pkg::KEY_RIGHT);
        enter = key_bit(kbd_pkg::KEY_ENTER);
        // name, pulse, length, bytes, bad parity, keys, pulse cycles
        add_row("hold_w_make",      1'b0, 1, 32'h1D000000, 1'b0, w, 0);
        add_row("hold_w_break",     1'b0, 2, 32'hF01D0000, 1'b0, '0, 0);
        add_row("hold_multi",       1'b0, 2, 32'h1D1C0000, 1'b0, w | a, 0);
        add_row("ext_right_make",   1'b0, 2, 32'hE0740000, 1'b0, w | a | right, 0);
        add_row("ext_right_break",  1'b0, 3, 32'hE0F07400, 1'b0, w | a, 0);
        add_row("bad_parity",       1'b0, 1, 32'h23000000, 1'b1, w | a, 0);
        add_row("good_after_bad",   1'b0, 1, 32'h23000000, 1'b0, w | a | d, 0);
        add_row("untracked",        1'b0, 3, 32'h15E01500, 1'b0, w | a | d, 0);
        add_row("pulse_space",      1'b1, 1, 32'h29000000, 1'b0, '0, 1);
        add_row("pulse_repeat",     1'b1, 1, 32'h29000000, 1'b0, '0, 0);
        add_row("pulse_release",    1'b1, 2, 32'hF0290000, 1'b0, '0, 0);
        add_row("pulse_enter",      1'b1, 1, 32'h5A000000, 1'b0, '0, 1);
        // Back in hold mode the press vector shows again
        add_row("hold_after_pulse", 1'b0, 0, 32'h00000000, 1'b0, w | a | d | enter, 0);
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %0h actual %0h", name, what, expected, actual);
            row_failed = 1'b1;
        end
    endtask

    task automatic note_timeout(input string name, input string what);
        $display("Test %s timed out while %s", name, what);
        row_failed = 1'b1;
    endtask

    // One frame through the model, then a random idle gap
    task automatic send_frame(input string name, input kbd_pkg::scan_byte_t data,
                              input logic corrupt);
        int t;
        @(posedge CLOCK_50);
        send       <= 1'b1;
        send_byte  <= data;
        bad_parity <= corrupt;
        t = 0;
        while (!busy && t < 16) begin
            @(posedge CLOCK_50);
            t++;
        end
        send <= 1'b0;
        if (!busy) begin
            note_timeout(name, "waiting for the keyboard model to start");
        end
        t = 0;
        while (busy && t < 30 * HALF_PERIOD) begin
            @(posedge CLOCK_50);
            t++;
        end
        if (busy) begin
            note_timeout(name, "waiting for the frame to finish");
        end
        repeat ($urandom_range(40, 8)) @(posedge CLOCK_50);
    endtask

    task automatic run_row(input int r);
        int t;
        int i;
        @(posedge CLOCK_50);
        pulse_mode <= row_pulse[r];
        @(posedge CLOCK_50);
        pulse_cnt  = 0;
        counting   = 1'b1;
        row_failed = 1'b0;
        for (i = 0; i < row_len[r]; i++) begin
            send_frame(row_name[r], row_seq[r][31 - 8*i -: 8], row_bad[r]);
        end
        // Outputs follow the last stop bit after the synchroniser delay
        t = 0;
        @(negedge CLOCK_50);
        while (keys !== row_keys[r] && t < 64) begin
            @(negedge CLOCK_50);
            t++;
        end
        if (keys !== row_keys[r]) begin
            note_timeout(row_name[r], "waiting for the key outputs");
        end
        // Settle window, pulses still counted
        repeat (16) @(negedge CLOCK_50);
        @(posedge CLOCK_50);
        counting = 1'b0;
        @(negedge CLOCK_50);
        compare_value(row_name[r], "keys", row_keys[r], keys);
        if (row_pulse[r]) begin
            compare_value(row_name[r], "pulses", row_pulses[r], pulse_cnt);
        end
    endtask

    task automatic tally(input string name);
        if (row_failed) begin
            fail_count++;
            $display("Test %s finished with errors", name);
        end else begin
            pass_count++;
            $display("PASS %s", name);
        end
    endtask

    // Reset with keys held must clear every output
    task automatic check_reset();
        row_failed = 1'b0;
        @(posedge CLOCK_50);
        reset <= 1'b0;
        repeat (3) @(posedge CLOCK_50);
        reset <= 1'b1;
        @(negedge CLOCK_50);
        compare_value("reset_clears", "keys", 0, keys);
        tally("reset_clears");
    endtask

    initial begin
        reset      = 1'b0;
        pulse_mode = 1'b0;
        send       = 1'b0;
        send_byte  = '0;
        bad_parity = 1'b0;
        void'($urandom(70687));
        load_table();
        repeat (3) @(posedge CLOCK_50);
        reset <= 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
            tally(row_name[r]);
        end
        check_reset();
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* verification/ps2_keyboard_model.sv */
`timescale 1ns/1ns

module ps2_keyboard_model #(
    parameter int HALF_PERIOD = 20
) (
    input  logic                CLOCK_50,
    input  logic                send,
    input  kbd_pkg::scan_byte_t send_byte,
    input  logic                bad_parity,
    output logic                busy,
    output logic                ps2_clk,
    output logic                ps2_dat
);

    // Outgoing frame, bit 0 goes first
    logic [10:0] frame;
    int          bit_idx;

    initial begin
        // Bus idle with both lines high
        busy    = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        forever begin
            @(posedge CLOCK_50);
            if (send) begin
                busy <= 1'b1;
                // Stop, odd parity (optionally flipped), data, start
                frame = {1'b1, (~^send_byte) ^ bad_parity, send_byte, 1'b0};
                for (bit_idx = 0; bit_idx < 11; bit_idx++) begin
                    // Data settles while the clock is high
                    ps2_dat <= frame[bit_idx];
                    repeat (HALF_PERIOD) @(posedge CLOCK_50);
                    // Host samples on this falling edge
                    ps2_clk <= 1'b0;
                    repeat (HALF_PERIOD) @(posedge CLOCK_50);
                    ps2_clk <= 1'b1;
                end
                ps2_dat <= 1'b1;
                busy    <= 1'b0;
            end
        end
    end

endmodule

/* hdl/keyboard_top.sv */
`timescale 1ns/1ns

module keyboard_top (
    input  logic              CLOCK_50,
    input  logic              reset,
    input  logic              pulse_mode,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    output kbd_pkg::key_vec_t keys
);

    // Receiver to decoder
    logic                byte_valid;
    kbd_pkg::scan_byte_t byte_data;

    // Decoder to key registers
    logic                upd_valid;
    kbd_pkg::key_idx_t   upd_key;
    logic                upd_make;

    ps2_rx ps2_rx_i (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    scan_code_decoder scan_code_decoder_i (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .upd_valid  (upd_valid),
        .upd_key    (upd_key),
        .upd_make   (upd_make)
    );

    key_state key_state_i (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .pulse_mode (pulse_mode),
        .upd_valid  (upd_valid),
        .upd_key    (upd_key),
        .upd_make   (upd_make),
        .keys       (keys)
    );

endmodule

/* hdl/key_state.sv */
`timescale 1ns/1ns

module key_state (
    input  logic              CLOCK_50,
    input  logic              reset,
    input  logic              pulse_mode,
    input  logic              upd_valid,
    input  kbd_pkg::key_idx_t upd_key,
    input  logic              upd_make,
    output kbd_pkg::key_vec_t keys
);

    // Current key levels as reported by the keyboard
    kbd_pkg::key_vec_t press;
    // Press delayed by one cycle
    kbd_pkg::key_vec_t lock;

    // Press bits written by the decoder updates
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            press <= '0;
        end else if (upd_valid) begin
            press[upd_key] <= upd_make;
        end
    end

    // Lock rises one cycle after press, so only the first cycle is unlocked
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            lock <= '0;
        end else begin
            lock <= press;
        end
    end

    // Hold mode shows press, pulse mode only the rising cycle
    // A typematic repeat rewrites a 1, so no second pulse
    assign keys = pulse_mode ? (press & ~lock) : press;

endmodule

/* hdl/scan_code_decoder.sv */
`timescale 1ns/1ns

module scan_code_decoder (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic                byte_valid,
    input  kbd_pkg::scan_byte_t byte_data,
    output logic                upd_valid,
    output kbd_pkg::key_idx_t   upd_key,
    output logic                upd_make
);

    kbd_pkg::code_state_t state;

    // Lookup result for the incoming byte
    logic              code_hit;
    kbd_pkg::key_idx_t code_key;

    // Map a scan code onto a key index
    always_comb begin
        code_hit = 1'b1;
        code_key = kbd_pkg::KEY_LEFT;
        case (byte_data)
            kbd_pkg::CODE_LEFT:  code_key = kbd_pkg::KEY_LEFT;
            kbd_pkg::CODE_RIGHT: code_key = kbd_pkg::KEY_RIGHT;
            kbd_pkg::CODE_UP:    code_key = kbd_pkg::KEY_UP;
            kbd_pkg::CODE_DOWN:  code_key = kbd_pkg::KEY_DOWN;
            kbd_pkg::CODE_W:     code_key = kbd_pkg::KEY_W;
            kbd_pkg::CODE_A:     code_key = kbd_pkg::KEY_A;
            kbd_pkg::CODE_S:     code_key = kbd_pkg::KEY_S;
            kbd_pkg::CODE_D:     code_key = kbd_pkg::KEY_D;
            kbd_pkg::CODE_SPACE: code_key = kbd_pkg::KEY_SPACE;
            kbd_pkg::CODE_ENTER: code_key = kbd_pkg::KEY_ENTER;
            // Untracked code or prefix
            default:             code_hit = 1'b0;
        endcase
    end

    // Expectation FSM
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            state <= kbd_pkg::ST_MAKE;
        end else if (byte_valid) begin
            if (byte_data == kbd_pkg::PREFIX_EXT) begin
                state <= kbd_pkg::ST_EXT_MAKE;
            end else if (byte_data == kbd_pkg::PREFIX_BREAK) begin
                // Break keeps the extended flag
                if (state == kbd_pkg::ST_EXT_MAKE || state == kbd_pkg::ST_EXT_BREAK) begin
                    state <= kbd_pkg::ST_EXT_BREAK;
                end else begin
                    state <= kbd_pkg::ST_BREAK;
                end
            end else begin
                // Any code byte ends the sequence
                state <= kbd_pkg::ST_MAKE;
            end
        end
    end

    // One cycle update strobe for tracked codes
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= byte_valid && code_hit;
        end
    end

    // Key and direction of the update
    always_ff @(posedge CLOCK_50) begin
        if (byte_valid && code_hit) begin
            upd_key  <= code_key;
            // Make in both make states, release in both break states
            upd_make <= (state == kbd_pkg::ST_MAKE) || (state == kbd_pkg::ST_EXT_MAKE);
        end
    end

endmodule

/* hdl/ps2_rx.sv */
`timescale 1ns/1ns

module ps2_rx (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output logic                byte_valid,
    output kbd_pkg::scan_byte_t byte_data
);

    // Two flop synchronisers for the keyboard lines
    logic clk_meta;
    logic clk_sync;
    logic dat_meta;
    logic dat_sync;

    // Previous synchronised clock level, for edge detection
    logic clk_prev;
    logic clk_fall;

    // Bits of the frame taken so far, start bit ends up in bit 0
    logic [9:0] shift_reg;
    // Number of bits sampled in the current frame, 0 to 10
    logic [3:0] bit_cnt;

    // Complete frame as seen on the stop bit edge
    logic [10:0] frame;
    logic        frame_ok;

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            // Lines idle high
            clk_meta <= 1'b1;
            clk_sync <= 1'b1;
            clk_prev <= 1'b1;
            dat_meta <= 1'b1;
            dat_sync <= 1'b1;
        end else begin
            clk_meta <= ps2_clk;
            clk_sync <= clk_meta;
            clk_prev <= clk_sync;
            dat_meta <= ps2_dat;
            dat_sync <= dat_meta;
        end
    end

    // Falling keyboard clock, seen one cycle after the synchronised level drops
    assign clk_fall = clk_prev & ~clk_sync;

    // Stop bit comes straight from the data line on the last edge
    assign frame = {dat_sync, shift_reg};

    // Start low, odd parity over data and parity bit, stop high
    assign frame_ok = (frame[0] == 1'b0) && (^frame[9:1] == 1'b1) && (frame[10] == 1'b1);

    // Bit counter
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            bit_cnt <= 4'd0;
        end else if (clk_fall) begin
            if (bit_cnt == 4'd10) begin
                bit_cnt <= 4'd0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // Shift in LSB first
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            shift_reg <= {dat_sync, shift_reg[9:1]};
        end
    end

    // Strobe goes out the cycle after the stop bit, bad frames are dropped
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= clk_fall && (bit_cnt == 4'd10) && frame_ok;
        end
    end

    // Payload only
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && (bit_cnt == 4'd10)) begin
            byte_data <= frame[8:1];
        end
    end

endmodule

/* hdl/kbd_pkg.sv */
package kbd_pkg;

    // One data byte taken from a PS/2 frame
    typedef logic [7:0] scan_byte_t;

    // Number of keys the tracker follows
    localparam int NUM_KEYS = 10;

    // Index of one tracked key
    typedef logic [3:0] key_idx_t;

    // One bit per tracked key, bit position is the key index
    typedef logic [NUM_KEYS-1:0] key_vec_t;

    // Key indices
    // Arrows sit in the low bits, then WASD, then space and enter
    localparam key_idx_t KEY_LEFT  = 4'd0;
    localparam key_idx_t KEY_RIGHT = 4'd1;
    localparam key_idx_t KEY_UP    = 4'd2;
    localparam key_idx_t KEY_DOWN  = 4'd3;
    localparam key_idx_t KEY_W     = 4'd4;
    localparam key_idx_t KEY_A     = 4'd5;
    localparam key_idx_t KEY_S     = 4'd6;
    localparam key_idx_t KEY_D     = 4'd7;
    localparam key_idx_t KEY_SPACE = 4'd8;
    localparam key_idx_t KEY_ENTER = 4'd9;

    // Scan Code Set 2 make codes of the tracked keys
    localparam scan_byte_t CODE_W     = 8'h1D;
    localparam scan_byte_t CODE_A     = 8'h1C;
    localparam scan_byte_t CODE_S     = 8'h1B;
    localparam scan_byte_t CODE_D     = 8'h23;
    // Arrow codes, sent after the E0 prefix
    localparam scan_byte_t CODE_LEFT  = 8'h6B;
    localparam scan_byte_t CODE_RIGHT = 8'h74;
    localparam scan_byte_t CODE_UP    = 8'h75;
    localparam scan_byte_t CODE_DOWN  = 8'h72;
    localparam scan_byte_t CODE_SPACE = 8'h29;
    localparam scan_byte_t CODE_ENTER = 8'h5A;

    // Prefix bytes
    localparam scan_byte_t PREFIX_EXT   = 8'hE0;
    localparam scan_byte_t PREFIX_BREAK = 8'hF0;

    // What kind of code the decoder expects next
    typedef enum logic [1:0] {
        ST_MAKE,
        ST_BREAK,
        ST_EXT_MAKE,
        ST_EXT_BREAK
    } code_state_t;

endpackage
